/* rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// ----------------------------------------
// Core sizing
// ----------------------------------------

// Data and address width
`define XLEN 32

// Architectural register count
`define REG_COUNT 32

// ----------------------------------------
// Reset state
// ----------------------------------------

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // ----------------------------------------
    // Major opcodes handled by the core
    // ----------------------------------------
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_e;

    // ALU functions, unsigned compare rides on comp_flag
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_slt = 4'd2,
        alu_xor = 4'd3,
        alu_or  = 4'd4,
        alu_and = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7,
        alu_sra = 4'd8
    } alu_op_e;

    // Immediate formats
    typedef enum logic [2:0] {
        imm_i     = 3'd0,
        imm_s     = 3'd1,
        imm_b     = 3'd2,
        imm_u     = 3'd3,
        imm_j     = 3'd4,
        imm_shamt = 3'd5
    } imm_sel_e;

    // Operand A source
    typedef enum logic [1:0] {
        rs1_reg  = 2'd0,
        rs1_pc   = 2'd1,
        rs1_zero = 2'd2
    } rs1_sel_e;

    // Write-back source
    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_load = 2'd1,
        wb_link = 2'd2
    } wb_sel_e;

endpackage

`default_nettype wire

/* ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;

    // Enables and flow flags
    logic               reg_wen;
    logic               mem_wen;
    logic               mem_ren;
    logic               jump_flag;
    logic               branch_flag;
    // Datapath selects
    rv_pkg::alu_op_e    alu_op;
    rv_pkg::imm_sel_e   imm_sel;
    rv_pkg::rs1_sel_e   rs1_sel;
    logic               rs2_imm;
    logic               comp_flag;
    logic               inv_flag;
    rv_pkg::wb_sel_e    wb_sel;

    modport decoder (
        output reg_wen, mem_wen, mem_ren, jump_flag, branch_flag,
        output alu_op, imm_sel, rs1_sel, rs2_imm, comp_flag, inv_flag, wb_sel
    );
    // ALU and immediate generator
    modport exec (input alu_op, imm_sel, rs1_sel, rs2_imm, comp_flag);
    // Register file write-back
    modport wb (input reg_wen, wb_sel);
    // PC unit
    modport flow (input jump_flag, branch_flag, inv_flag);

endinterface

`default_nettype wire

/* rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_decoder (
    input  logic [`XLEN-1:0] inst,
    ctrl_if.decoder          ctrl
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic            is_op;
    rv_pkg::alu_op_e arith_op;

    // Instruction fields
    assign opcode    = rv_pkg::opcode_e'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];
    assign is_op     = (opcode == rv_pkg::opc_op);

    // ----------------------------------------
    // Arithmetic op for OP and OP-IMM
    // ----------------------------------------
    always_comb begin
        case (funct3)
            // addi has no sub form, bit 30 is immediate there
            3'b000: arith_op = (is_op && funct7_b5) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001: arith_op = rv_pkg::alu_sll;
            3'b010: arith_op = rv_pkg::alu_slt;
            3'b011: arith_op = rv_pkg::alu_slt;
            3'b100: arith_op = rv_pkg::alu_xor;
            // srai keeps bit 30 in its encoding
            3'b101: arith_op = funct7_b5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110: arith_op = rv_pkg::alu_or;
            default: arith_op = rv_pkg::alu_and;
        endcase
    end

    // ----------------------------------------
    // Control flags per opcode
    // ----------------------------------------
    always_comb begin
        // Safe defaults, no writes and add
        ctrl.reg_wen     = 1'b0;
        ctrl.mem_wen     = 1'b0;
        ctrl.mem_ren     = 1'b0;
        ctrl.jump_flag   = 1'b0;
        ctrl.branch_flag = 1'b0;
        ctrl.alu_op      = rv_pkg::alu_add;
        ctrl.imm_sel     = rv_pkg::imm_i;
        ctrl.rs1_sel     = rv_pkg::rs1_reg;
        ctrl.rs2_imm     = 1'b1;
        ctrl.comp_flag   = 1'b0;
        ctrl.inv_flag    = 1'b0;
        ctrl.wb_sel      = rv_pkg::wb_alu;
        case (opcode)
            rv_pkg::opc_op: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.rs2_imm   = 1'b0;
                ctrl.alu_op    = arith_op;
                ctrl.comp_flag = (funct3 == 3'b011);
            end
            rv_pkg::opc_op_imm: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.alu_op    = arith_op;
                ctrl.comp_flag = (funct3 == 3'b011);
                // Shifts take only the 5-bit shamt
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl.imm_sel = rv_pkg::imm_shamt;
                end
            end
            rv_pkg::opc_load: begin
                ctrl.reg_wen = 1'b1;
                ctrl.mem_ren = 1'b1;
                ctrl.wb_sel  = rv_pkg::wb_load;
            end
            rv_pkg::opc_store: begin
                ctrl.mem_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::imm_s;
            end
            rv_pkg::opc_branch: begin
                ctrl.branch_flag = 1'b1;
                ctrl.rs2_imm     = 1'b0;
                ctrl.imm_sel     = rv_pkg::imm_b;
                // beq/bne subtract, the rest compare
                ctrl.alu_op      = funct3[2] ? rv_pkg::alu_slt : rv_pkg::alu_sub;
                // bltu and bgeu
                ctrl.comp_flag   = funct3[2] & funct3[1];
                // Taken on nonzero result for bne, blt, bltu
                ctrl.inv_flag    = funct3[2] ? ~funct3[0] : funct3[0];
            end
            rv_pkg::opc_jal: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.jump_flag = 1'b1;
                ctrl.imm_sel   = rv_pkg::imm_j;
                ctrl.rs1_sel   = rv_pkg::rs1_pc;
                ctrl.wb_sel    = rv_pkg::wb_link;
            end
            rv_pkg::opc_jalr: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.jump_flag = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_link;
            end
            rv_pkg::opc_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::imm_u;
                ctrl.rs1_sel = rv_pkg::rs1_zero;
            end
            rv_pkg::opc_auipc: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::imm_u;
                ctrl.rs1_sel = rv_pkg::rs1_pc;
            end
            default: begin
                // Unknown opcode keeps the defaults
                ctrl.reg_wen = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module imm_gen (
    input  logic [`XLEN-1:0] inst,
    ctrl_if.exec             ctrl,
    output logic [`XLEN-1:0] imm
);

    // Sign bit of every signed format
    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (ctrl.imm_sel)
            rv_pkg::imm_i: imm = {{(`XLEN-12){sign}}, inst[31:20]};
            // Store offset split around rd field
            rv_pkg::imm_s: imm = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};
            // Branch offset, halfword aligned
            rv_pkg::imm_b: begin
                imm = {{(`XLEN-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            // Upper 20 bits, low 12 cleared
            rv_pkg::imm_u: imm = {inst[31:12], 12'b0};
            // Jump offset, halfword aligned
            rv_pkg::imm_j: begin
                imm = {{(`XLEN-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            // Shift amount, zero extended
            rv_pkg::imm_shamt: imm = {{(`XLEN-5){1'b0}}, inst[24:20]};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module alu (
    ctrl_if.exec             ctrl,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic             less;

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------
    always_comb begin
        case (ctrl.rs1_sel)
            rv_pkg::rs1_pc:   op_a = pc;
            // lui adds the immediate to zero
            rv_pkg::rs1_zero: op_a = '0;
            default:          op_a = rs1_data;
        endcase
    end

    assign op_b  = ctrl.rs2_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];

    // Unsigned compare for sltu, sltiu, bltu, bgeu
    assign less = ctrl.comp_flag ? (op_a < op_b) : ($signed(op_a) < $signed(op_b));

    // ----------------------------------------
    // Function select
    // ----------------------------------------
    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_add: result = op_a + op_b;
            rv_pkg::alu_sub: result = op_a - op_b;
            rv_pkg::alu_slt: result = {{(`XLEN-1){1'b0}}, less};
            rv_pkg::alu_xor: result = op_a ^ op_b;
            rv_pkg::alu_or:  result = op_a | op_b;
            rv_pkg::alu_and: result = op_a & op_b;
            rv_pkg::alu_sll: result = op_a << shamt;
            rv_pkg::alu_srl: result = op_a >> shamt;
            // Arithmetic shift keeps the sign
            rv_pkg::alu_sra: result = $signed(op_a) >>> shamt;
            default:         result = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    ctrl_if.wb               ctrl,
    input  logic [`XLEN-1:0] inst,
    input  logic [`XLEN-1:0] alu_result,
    input  logic [`XLEN-1:0] load_data,
    input  logic [`XLEN-1:0] link_pc,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic [4:0]       rs1_idx;
    logic [4:0]       rs2_idx;
    logic [4:0]       rd_idx;
    logic [`XLEN-1:0] wb_data;

    // Indices straight from the instruction
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];
    assign rd_idx  = inst[11:7];

    // Asynchronous reads, x0 always zero
    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

    // Write-back source
    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::wb_load: wb_data = load_data;
            rv_pkg::wb_link: wb_data = link_pc;
            default:         wb_data = alu_result;
        endcase
    end

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_wen && rd_idx != 5'd0) begin
            regs[rd_idx] <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module pc_unit (
    input  logic             clk,
    input  logic             rst_n,
    ctrl_if.flow             ctrl,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] alu_result,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] link_pc,
    output logic [`XLEN-1:0] pc_next_dbg
);

    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] branch_target;
    logic             take_branch;

    // Sequential successor, also the link value
    assign link_pc = pc + `XLEN'(4);

    // Own adder for the branch target
    assign branch_target = pc + imm;

    // Zero test flipped for bne, blt, bltu
    assign take_branch = ctrl.branch_flag & ((alu_result == '0) ^ ctrl.inv_flag);

    // ----------------------------------------
    // Next PC
    // ----------------------------------------
    always_comb begin
        if (ctrl.jump_flag) begin
            // jal and jalr clear bit 0 of the sum
            pc_next = {alu_result[`XLEN-1:1], 1'b0};
        end else if (take_branch) begin
            pc_next = branch_target;
        end else begin
            pc_next = link_pc;
        end
    end

    assign pc_next_dbg = pc_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_core (
    input  logic             clk,
    input  logic             rst_n,
    // Instruction memory
    input  logic [`XLEN-1:0] inst,
    output logic [`XLEN-1:0] inst_addr,
    // Data memory
    input  logic [`XLEN-1:0] dmem_rdata,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    output logic             dmem_wen,
    output logic             dmem_ren
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] link_pc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_result;

    // Decoded control bundle
    ctrl_if ctrl ();

    // ----------------------------------------
    // Decode and execute
    // ----------------------------------------
    rv_decoder u_decoder (.inst(inst), .ctrl(ctrl.decoder));

    imm_gen u_imm_gen (.inst(inst), .ctrl(ctrl.exec), .imm(imm));

    alu u_alu (
        .ctrl     (ctrl.exec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (alu_result)
    );

    // ----------------------------------------
    // State
    // ----------------------------------------
    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl.wb),
        .inst       (inst),
        .alu_result (alu_result),
        .load_data  (dmem_rdata),
        .link_pc    (link_pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    pc_unit u_pc_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl.flow),
        .imm         (imm),
        .alu_result  (alu_result),
        .pc          (pc),
        .link_pc     (link_pc),
        .pc_next_dbg ()
    );

    // Memory ports
    assign inst_addr  = pc;
    // ALU sum as address and rs2 as store data
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    // No memory access while in reset
    assign dmem_wen   = ctrl.mem_wen & rst_n;
    assign dmem_ren   = ctrl.mem_ren & rst_n;

endmodule

`default_nettype wire

/* rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_config.svh"

module rv_core_tb;

    localparam int MEM_WORDS = 256;
    // Cycle budget for the whole program
    localparam int RUN_LIMIT = 500;
    // sw x0, 0(x0) and lw x0, 0(x0)
    localparam logic [`XLEN-1:0] STORE_PROBE = 32'h0000_2023;
    localparam logic [`XLEN-1:0] LOAD_PROBE  = 32'h0000_2003;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] inst_addr;
    logic [`XLEN-1:0] dmem_rdata;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic             dmem_wen;
    logic             dmem_ren;

    // Word-addressed memory models
    logic [`XLEN-1:0] imem [MEM_WORDS];
    logic [`XLEN-1:0] dmem [MEM_WORDS];

    // Expected stores in program order
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];

    int value_errors;
    int other_errors;
    int store_count;
    int total_stores;
    int cycles;
    int stable;
    logic [`XLEN-1:0] last_pc;
    logic [`XLEN-1:0] boot_word;

    rv_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_addr  (inst_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .dmem_ren   (dmem_ren)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------
    // Memory models
    // ----------------------------------------
    // Zero-wait reads
    assign inst       = imem[inst_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    // Store commits on the rising edge
    always @(posedge clk) begin
        if (dmem_wen) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // ----------------------------------------
    // Trace loading
    // ----------------------------------------
    task automatic read_trace();
        int               fd;
        int               n;
        string            line;
        logic [7:0]       code;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] word;
        fd = $fopen("rv_core_trace.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the trace file rv_core_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%c %h %h", code, addr, word);
                    // Comment lines give fewer than three fields
                    if (n == 3) begin
                        case (code)
                            "P": imem[addr[9:2]] = word;
                            "M": dmem[addr[9:2]] = word;
                            "S": begin
                                exp_addr.push_back(addr);
                                exp_data.push_back(word);
                            end
                            default: ;
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic expect_reset_outputs();
        assert (inst_addr === `RESET_PC) else begin
            value_errors++;
            $display("Error inst_addr: expected %h, got %h", `RESET_PC, inst_addr);
        end
        assert (dmem_wen === 1'b0) else begin
            value_errors++;
            $display("Error dmem_wen: expected %h, got %h", 1'b0, dmem_wen);
        end
        assert (dmem_ren === 1'b0) else begin
            value_errors++;
            $display("Error dmem_ren: expected %h, got %h", 1'b0, dmem_ren);
        end
    endtask

    // Compare a pending store with the next S record
    task automatic compare_store();
        logic [`XLEN-1:0] want_addr;
        logic [`XLEN-1:0] want_data;
        if (dmem_wen === 1'b1) begin
            store_count++;
            assert (exp_addr.size() > 0) else begin
                other_errors++;
                $display("Unexpected extra store to %h with data %h", dmem_addr, dmem_wdata);
            end
            if (exp_addr.size() > 0) begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                assert (dmem_addr === want_addr) else begin
                    value_errors++;
                    $display("Error dmem_addr: expected %h, got %h", want_addr, dmem_addr);
                end
                assert (dmem_wdata === want_data) else begin
                    value_errors++;
                    $display("Error dmem_wdata: expected %h, got %h", want_data, dmem_wdata);
                end
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_n        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        store_count  = 0;
        // Blank program and address-tagged data words
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hd0d0_0000 | (i << 2);
        end
        read_trace();
        total_stores = exp_addr.size();

        // A store and then a load sit at the reset PC during reset
        boot_word = imem[0];
        imem[0]   = STORE_PROBE;
        @(posedge clk);
        @(negedge clk);
        expect_reset_outputs();
        @(posedge clk);
        imem[0] <= LOAD_PROBE;
        @(negedge clk);
        expect_reset_outputs();
        @(posedge clk);
        imem[0] <= boot_word;
        rst_n   <= 1'b1;

        // First cycle out of reset still fetches from the reset PC
        @(negedge clk);
        assert (inst_addr === `RESET_PC) else begin
            value_errors++;
            $display("Error inst_addr: expected %h, got %h", `RESET_PC, inst_addr);
        end
        compare_store();

        // Run until the PC sits on the self-loop
        last_pc = inst_addr;
        stable  = 0;
        cycles  = 0;
        while (stable < 2 && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            compare_store();
            if (inst_addr === last_pc) begin
                stable++;
            end else begin
                stable = 0;
            end
            last_pc = inst_addr;
        end
        assert (stable >= 2) else begin
            other_errors++;
            $display("Timeout: the core never settled on its final loop in %0d cycles",
                     RUN_LIMIT);
        end
        assert (store_count == total_stores) else begin
            other_errors++;
            $display("Store count wrong: saw %0d stores but the trace lists %0d",
                     store_count, total_stores);
        end

        $display("Run finished: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core_trace.txt */
# Columns: code address word (hex); P = program word, M = initial data word,
# S = expected store address and data in order; text after the third field is ignored
P 00000000 10000093 addi x1, x0, 0x100
P 00000004 0000a103 lw x2, 0(x1)
P 00000008 0040a183 lw x3, 4(x1)
P 0000000c 00310233 add x4, x2, x3
P 00000010 0440a023 sw x4, 0x40(x1)
P 00000014 403102b3 sub x5, x2, x3
P 00000018 0450a223 sw x5, 0x44(x1)
P 0000001c 0021a333 slt x6, x3, x2
P 00000020 0021b3b3 sltu x7, x3, x2
P 00000024 0460a423 sw x6, 0x48(x1)
P 00000028 0470a623 sw x7, 0x4c(x1)
P 0000002c fff14413 xori x8, x2, -1
P 00000030 0480a823 sw x8, 0x50(x1)
P 00000034 003164b3 or x9, x2, x3
P 00000038 0490aa23 sw x9, 0x54(x1)
P 0000003c 0ff17513 andi x10, x2, 0xff
P 00000040 04a0ac23 sw x10, 0x58(x1)
P 00000044 00411593 slli x11, x2, 4
P 00000048 04b0ae23 sw x11, 0x5c(x1)
P 0000004c 4021d613 srai x12, x3, 2
P 00000050 0041d693 srli x13, x3, 4
P 00000054 06c0a023 sw x12, 0x60(x1)
P 00000058 06d0a223 sw x13, 0x64(x1)
P 0000005c abcde737 lui x14, 0xabcde
P 00000060 00001797 auipc x15, 0x1
P 00000064 06e0a423 sw x14, 0x68(x1)
P 00000068 06f0a623 sw x15, 0x6c(x1)
P 0000006c 00630463 beq x6, x6, +8 taken
P 00000070 0640a823 sw x4, 0x70(x1) skipped
P 00000074 00730463 beq x6, x7, +8 not taken
P 00000078 0650aa23 sw x5, 0x74(x1)
P 0000007c 00731463 bne x6, x7, +8 taken
P 00000080 0660ac23 sw x6, 0x78(x1) skipped
P 00000084 00631463 bne x6, x6, +8 not taken
P 00000088 0670ae23 sw x7, 0x7c(x1)
P 0000008c 0021c463 blt x3, x2, +8 taken
P 00000090 0880a023 sw x8, 0x80(x1) skipped
P 00000094 00314463 blt x2, x3, +8 not taken
P 00000098 0890a223 sw x9, 0x84(x1)
P 0000009c 00315463 bge x2, x3, +8 taken
P 000000a0 08a0a423 sw x10, 0x88(x1) skipped
P 000000a4 0021d463 bge x3, x2, +8 not taken
P 000000a8 08b0a623 sw x11, 0x8c(x1)
P 000000ac 00316463 bltu x2, x3, +8 taken
P 000000b0 08c0a823 sw x12, 0x90(x1) skipped
P 000000b4 0021e463 bltu x3, x2, +8 not taken
P 000000b8 08d0aa23 sw x13, 0x94(x1)
P 000000bc 0021f463 bgeu x3, x2, +8 taken
P 000000c0 08e0ac23 sw x14, 0x98(x1) skipped
P 000000c4 00317463 bgeu x2, x3, +8 not taken
P 000000c8 08f0ae23 sw x15, 0x9c(x1)
P 000000cc 008008ef jal x17, +8
P 000000d0 0a40a023 sw x4, 0xa0(x1) skipped
P 000000d4 0b10a223 sw x17, 0xa4(x1)
P 000000d8 01588967 jalr x18, 0x15(x17) lands on 0xe4
P 000000dc 0a40a423 sw x4, 0xa8(x1) skipped
P 000000e0 0a50a623 sw x5, 0xac(x1) skipped
P 000000e4 0b20a823 sw x18, 0xb0(x1)
P 000000e8 0000006f jal x0, 0 final loop
# Source operands for the loads
M 00000100 12345678
M 00000104 fffffff0
# Arithmetic and logic results
S 00000140 12345668
S 00000144 12345688
S 00000148 00000001
S 0000014c 00000000
S 00000150 edcba987
S 00000154 fffffff8
S 00000158 00000078
S 0000015c 23456780
S 00000160 fffffffc
S 00000164 0fffffff
S 00000168 abcde000
S 0000016c 00001060
# Branch fall-through markers
S 00000174 12345688
S 0000017c 00000000
S 00000184 fffffff8
S 0000018c 23456780
S 00000194 0fffffff
S 0000019c 00001060
# Link values
S 000001a4 000000d0
S 000001b0 000000dc

/* rv_core.f */
+incdir+.
rv_pkg.sv
ctrl_if.sv
rv_decoder.sv
imm_gen.sv
alu.sv
reg_file.sv
pc_unit.sv
rv_core.sv
rv_core_tb.sv
